/* logic/afu_pkg.sv */
//==========================================================================
// Accelerator shell definitions
// Widths, APB register map, DMA port structs and the state encodings
// shared by the register file, the memory controller and the word engine
//==========================================================================

package afu_pkg;

   // ======================================================================
   // Widths
   // ======================================================================
   localparam int ADDR_W         = 64;
   localparam int LINE_COUNT_W   = 16;
   localparam int WORD_W         = 32;
   localparam int LINE_W         = 512;
   localparam int WORDS_PER_LINE = 16;
   localparam int WORD_IDX_W     = 4;
   localparam int APB_ADDR_W     = 8;

   // A transfer counted in words is the line count times 16
   localparam int WORD_CNT_W     = LINE_COUNT_W + WORD_IDX_W;

   typedef logic [ADDR_W-1:0]       byte_addr_t;
   typedef logic [LINE_COUNT_W-1:0] line_count_t;
   typedef logic [WORD_W-1:0]       word_t;
   typedef logic [LINE_W-1:0]       line_t;
   typedef logic [WORD_IDX_W-1:0]   word_idx_t;
   typedef logic [APB_ADDR_W-1:0]   apb_addr_t;

   // ======================================================================
   // APB register map
   // ======================================================================
   localparam apb_addr_t REG_CTRL       = 8'h00;
   localparam apb_addr_t REG_STATUS     = 8'h04;
   localparam apb_addr_t REG_RD_ADDR_LO = 8'h08;
   localparam apb_addr_t REG_RD_ADDR_HI = 8'h0C;
   localparam apb_addr_t REG_WR_ADDR_LO = 8'h10;
   localparam apb_addr_t REG_WR_ADDR_HI = 8'h14;
   localparam apb_addr_t REG_SIZE       = 8'h18;
   localparam apb_addr_t REG_CHECKSUM   = 8'h1C;

   // Shell to host DMA, with go pulses and single cycle enables
   typedef struct packed {
      byte_addr_t  rd_addr;
      byte_addr_t  wr_addr;
      line_count_t rd_size;
      line_count_t wr_size;
      logic        rd_go;
      logic        wr_go;
      logic        rd_en;
      logic        wr_en;
      line_t       wr_data;
   } dma_req_t;

   // Host DMA to shell, where empty and full are the flow control
   typedef struct packed {
      line_t rd_data;
      logic  empty;
      logic  full;
      logic  rd_done;
      logic  wr_done;
   } dma_rsp_t;

   // Word request from the engine to the memory controller
   typedef enum logic [1:0] {op_idle, op_read, op_write} mem_op_t;

   typedef enum logic [1:0] {cs_idle, cs_start, cs_run} ctrl_state_t;
   typedef enum logic [1:0] {es_idle, es_read, es_write} eng_state_t;

endpackage

/* logic/mmio_regs.sv */
`timescale 1ns/1ps
//==========================================================================
// APB register file
// Holds the copy setup, raises the one cycle go pulse, tracks busy and
// done, and reads back the checksum from the word engine
//==========================================================================

module mmio_regs
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  apb_addr_t   paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  word_t       pwdata,
   output word_t       prdata,
   output logic        pready,
   output logic        pslverr,
   output byte_addr_t  rd_addr,
   output byte_addr_t  wr_addr,
   output line_count_t size,
   output logic        go,
   input  logic        xfer_done,
   input  word_t       checksum
);

   logic wr_access;
   logic start;
   logic busy;
   logic done;

   // No wait states and no error responses
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   // A write commits on the clock edge that ends the access phase
   assign wr_access = psel & penable & pwrite;

   // Go is only accepted between transfers
   assign start = wr_access && (paddr == REG_CTRL) && pwdata[0] && !busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         go      <= 1'b0;
         busy    <= 1'b0;
         done    <= 1'b0;
         rd_addr <= '0;
         wr_addr <= '0;
         size    <= '0;
      end else begin
         // The pulse lands in the cycle after the access phase
         go <= start;

         // Busy covers the whole span from go to the end of the last line write
         if (start) begin
            busy <= 1'b1;
         end else if (xfer_done) begin
            busy <= 1'b0;
         end

         // A new go clears the previous result
         if (start) begin
            done <= 1'b0;
         end else if (xfer_done) begin
            done <= 1'b1;
         end

         if (wr_access) begin
            case (paddr)
               REG_RD_ADDR_LO: rd_addr[31:0]  <= pwdata;
               REG_RD_ADDR_HI: rd_addr[63:32] <= pwdata;
               REG_WR_ADDR_LO: wr_addr[31:0]  <= pwdata;
               REG_WR_ADDR_HI: wr_addr[63:32] <= pwdata;
               REG_SIZE:       size           <= pwdata[LINE_COUNT_W-1:0];
               default:        ;
            endcase
         end
      end
   end

   // Read data is combinational so it is valid during the access phase
   always_comb begin
      case (paddr)
         REG_STATUS:     prdata = {30'b0, busy, done};
         REG_RD_ADDR_LO: prdata = rd_addr[31:0];
         REG_RD_ADDR_HI: prdata = rd_addr[63:32];
         REG_WR_ADDR_LO: prdata = wr_addr[31:0];
         REG_WR_ADDR_HI: prdata = wr_addr[63:32];
         REG_SIZE:       prdata = {{(WORD_W-LINE_COUNT_W){1'b0}}, size};
         REG_CHECKSUM:   prdata = checksum;
         // Control is write only and reads as zero
         default:        prdata = '0;
      endcase
   end

   // The busy lockout must keep go to a single cycle
   go_single_cycle_a: assert property (@(posedge clk) disable iff (!rst_n)
      go |=> !go);

endmodule

/* logic/mem_ctrl.sv */
`timescale 1ns/1ps
//==========================================================================
// Memory controller
// Bridges single word requests from the word engine to the cache line
// DMA port, splitting read lines and packing write lines
//==========================================================================

module mem_ctrl
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        go,
   input  byte_addr_t  rd_addr,
   input  byte_addr_t  wr_addr,
   input  line_count_t size,
   input  mem_op_t     op,
   input  word_t       wr_word,
   output word_t       rd_word,
   output logic        ack,
   output logic        xfer_done,
   output dma_req_t    dma_req,
   input  dma_rsp_t    dma_rsp
);

   localparam word_idx_t LAST_IDX = word_idx_t'(WORDS_PER_LINE - 1);

   ctrl_state_t state;

   // Transfer setup captured at go and held until the next go
   byte_addr_t  rd_addr_q;
   byte_addr_t  wr_addr_q;
   line_count_t size_q;

   // Word i of a line sits in bits [32*i +: 32]
   line_t     rd_line;
   // The write buffer holds words 0 to 14, word 15 arrives with the push
   logic [LINE_W-WORD_W-1:0] wr_line;
   word_idx_t rd_idx;
   word_idx_t wr_idx;
   logic      rd_valid;

   logic all_done;
   logic done_q;
   logic run;
   logic rd_pop;
   logic rd_serve;
   logic wr_last;
   logic wr_push;
   logic wr_take;

   assign run = (state == cs_run);

   // Pop a new line only when the read buffer is drained and the host has data
   assign rd_pop   = run && (op == op_read) && !rd_valid && !dma_rsp.empty;
   assign rd_serve = run && (op == op_read) && rd_valid;

   // The 16th word completes the line and goes straight out with it
   assign wr_last = (wr_idx == LAST_IDX);
   assign wr_push = run && (op == op_write) && wr_last && !dma_rsp.full;
   assign wr_take = (run && (op == op_write) && !wr_last) || wr_push;

   assign ack     = rd_serve || wr_take;
   assign rd_word = rd_line[32'(rd_idx) * WORD_W +: WORD_W];

   // Both channels finished, the write side always being the later one
   assign all_done = dma_rsp.rd_done & dma_rsp.wr_done;

   always_comb begin
      dma_req.rd_addr = rd_addr_q;
      dma_req.wr_addr = wr_addr_q;
      dma_req.rd_size = size_q;
      dma_req.wr_size = size_q;
      dma_req.rd_go   = (state == cs_start);
      dma_req.wr_go   = (state == cs_start);
      dma_req.rd_en   = rd_pop;
      dma_req.wr_en   = wr_push;
      // The last word bypasses the buffer
      dma_req.wr_data = {wr_word, wr_line};
   end

   // ======================================================================
   // Control state
   // ======================================================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= cs_idle;
         xfer_done <= 1'b0;
         done_q    <= 1'b0;
         rd_valid  <= 1'b0;
         rd_idx    <= '0;
         wr_idx    <= '0;
      end else begin
         xfer_done <= 1'b0;
         // Level from a previous transfer must not look like a new edge
         done_q    <= all_done;
         case (state)
            cs_idle: begin
               if (go) begin
                  state    <= cs_start;
                  rd_valid <= 1'b0;
                  rd_idx   <= '0;
                  wr_idx   <= '0;
               end
            end
            // The go pulses are driven for this single cycle
            cs_start: state <= cs_run;
            cs_run: begin
               if (all_done && !done_q) begin
                  state     <= cs_idle;
                  xfer_done <= 1'b1;
               end
            end
            default: state <= cs_idle;
         endcase

         if (rd_pop) begin
            rd_valid <= 1'b1;
         end else if (rd_serve) begin
            rd_idx <= rd_idx + 1'b1;
            // The index wraps to zero together with draining the line
            if (rd_idx == LAST_IDX) begin
               rd_valid <= 1'b0;
            end
         end

         if (wr_take) begin
            wr_idx <= wr_idx + 1'b1;
         end
      end
   end

   // ======================================================================
   // Setup and line buffers
   // ======================================================================
   always_ff @(posedge clk) begin
      if (state == cs_idle && go) begin
         rd_addr_q <= rd_addr;
         wr_addr_q <= wr_addr;
         size_q    <= size;
      end
      if (rd_pop) begin
         rd_line <= dma_rsp.rd_data;
      end
      if (wr_take && !wr_last) begin
         wr_line[32'(wr_idx) * WORD_W +: WORD_W] <= wr_word;
      end
   end

   // Engine requests outside a transfer would never be acknowledged
   op_in_xfer_a: assert property (@(posedge clk) disable iff (!rst_n)
      (op != op_idle) |-> (state != cs_idle));

endmodule

/* logic/word_engine.sv */
`timescale 1ns/1ps
//==========================================================================
// Word engine
// Copies the transfer one word at a time through the memory controller,
// reading each word, writing it back and summing it into a checksum
//==========================================================================

module word_engine
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        go,
   input  line_count_t size,
   output mem_op_t     op,
   output word_t       wr_word,
   input  word_t       rd_word,
   input  logic        ack,
   output word_t       checksum
);

   eng_state_t state;

   // Words still to be copied, counting down to zero
   logic [WORD_CNT_W-1:0] words_left;

   // Last word read, held as the write data
   word_t data_q;

   // The request follows the state, so it stays put until ack
   always_comb begin
      case (state)
         es_read:  op = op_read;
         es_write: op = op_write;
         default:  op = op_idle;
      endcase
   end

   assign wr_word = data_q;

   // ======================================================================
   // Sequencer
   // ======================================================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= es_idle;
         words_left <= '0;
         checksum   <= '0;
      end else begin
         case (state)
            es_idle: begin
               if (go) begin
                  // A new transfer starts the sum from zero
                  checksum   <= '0;
                  words_left <= {size, {WORD_IDX_W{1'b0}}};
                  // An empty transfer has nothing to copy
                  if (size != '0) begin
                     state <= es_read;
                  end
               end
            end
            es_read: begin
               if (ack) begin
                  // Wraps modulo 2**32
                  checksum <= checksum + rd_word;
                  state    <= es_write;
               end
            end
            es_write: begin
               if (ack) begin
                  words_left <= words_left - 1'b1;
                  if (words_left == WORD_CNT_W'(1)) begin
                     state <= es_idle;
                  end else begin
                     state <= es_read;
                  end
               end
            end
            default: state <= es_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == es_read && ack) begin
         data_q <= rd_word;
      end
   end

   // A stalled request may not be withdrawn or changed
   op_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
      (op != op_idle && !ack) |=> (op == $past(op)));

endmodule

/* logic/afu_top.sv */
`timescale 1ns/1ps
//==========================================================================
// Accelerator shell top level
// APB register port in, cache line DMA port out, with the word engine
// copying through the memory controller in between
//==========================================================================

module afu_top
   import afu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  apb_addr_t paddr,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  word_t     pwdata,
   output word_t     prdata,
   output logic      pready,
   output logic      pslverr,
   output dma_req_t  dma_req,
   input  dma_rsp_t  dma_rsp
);

   // Transfer setup from the registers
   byte_addr_t  rd_addr;
   byte_addr_t  wr_addr;
   line_count_t size;
   logic        go;

   // Results going back to software
   logic  xfer_done;
   word_t checksum;

   // Word request between engine and memory controller
   mem_op_t op;
   word_t   wr_word;
   word_t   rd_word;
   logic    ack;

   mmio_regs mmio_regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .rd_addr   (rd_addr),
      .wr_addr   (wr_addr),
      .size      (size),
      .go        (go),
      .xfer_done (xfer_done),
      .checksum  (checksum)
   );

   mem_ctrl mem_ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .go        (go),
      .rd_addr   (rd_addr),
      .wr_addr   (wr_addr),
      .size      (size),
      .op        (op),
      .wr_word   (wr_word),
      .rd_word   (rd_word),
      .ack       (ack),
      .xfer_done (xfer_done),
      .dma_req   (dma_req),
      .dma_rsp   (dma_rsp)
   );

   // The engine and the controller see the same go pulse
   word_engine word_engine_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .go       (go),
      .size     (size),
      .op       (op),
      .wr_word  (wr_word),
      .rd_word  (rd_word),
      .ack      (ack),
      .checksum (checksum)
   );

endmodule

/* tests/host_mem_model.sv */
`timescale 1ns/1ps
//==========================================================================
// Host memory and DMA responder
// Serves cache line reads and accepts line writes over the DMA structs,
// with random empty and full stalls and a flow control violation flag
//==========================================================================

module host_mem_model
   import afu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  dma_req_t    dma_req,
   output dma_rsp_t    dma_rsp,
   input  int          stall_pct,
   output logic        flow_err,
   output byte_addr_t  seen_rd_addr,
   output byte_addr_t  seen_wr_addr,
   output line_count_t seen_rd_size,
   output line_count_t seen_wr_size
);

   // Sparse memory, one entry per line address
   line_t mem [byte_addr_t];

   byte_addr_t  rd_base;
   byte_addr_t  wr_base;
   line_count_t rd_lines;
   line_count_t wr_lines;
   int unsigned rd_cnt;
   int unsigned wr_cnt;

   function automatic line_t fetch(byte_addr_t a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return '0;
   endfunction

   // True for roughly stall_pct percent of the calls
   function automatic logic stall();
      return int'($urandom % 100) < stall_pct;
   endfunction

   always @(posedge clk) begin : respond
      byte_addr_t  rd_b;
      byte_addr_t  wr_b;
      line_count_t rd_n;
      line_count_t wr_n;
      int unsigned rd_next;
      int unsigned wr_next;
      if (!rst_n) begin
         dma_rsp.empty   <= 1'b1;
         dma_rsp.full    <= 1'b1;
         dma_rsp.rd_done <= 1'b0;
         dma_rsp.wr_done <= 1'b0;
         dma_rsp.rd_data <= '0;
         flow_err        <= 1'b0;
         rd_lines        <= '0;
         wr_lines        <= '0;
         rd_cnt          <= 0;
         wr_cnt          <= 0;
         rd_base         <= '0;
         wr_base         <= '0;
      end else begin
         rd_b    = rd_base;
         wr_b    = wr_base;
         rd_n    = rd_lines;
         wr_n    = wr_lines;
         rd_next = rd_cnt;
         wr_next = wr_cnt;

         // Pops and pushes against a raised flag are protocol errors
         if (dma_req.rd_en && dma_rsp.empty) begin
            flow_err <= 1'b1;
         end
         if (dma_req.wr_en && dma_rsp.full) begin
            flow_err <= 1'b1;
         end

         // ================================================================
         // Read channel
         // ================================================================
         if (dma_req.rd_go) begin
            rd_b            = dma_req.rd_addr;
            rd_n            = dma_req.rd_size;
            rd_next         = 0;
            seen_rd_addr    <= dma_req.rd_addr;
            seen_rd_size    <= dma_req.rd_size;
            dma_rsp.rd_done <= (dma_req.rd_size == '0);
         end else if (dma_req.rd_en && !dma_rsp.empty) begin
            rd_next = rd_cnt + 1;
            if (rd_next == 32'(rd_n)) begin
               dma_rsp.rd_done <= 1'b1;
            end
         end
         rd_base         <= rd_b;
         rd_lines        <= rd_n;
         rd_cnt          <= rd_next;
         dma_rsp.rd_data <= fetch(rd_b + (byte_addr_t'(rd_next) << 6));
         dma_rsp.empty   <= !(rd_next < 32'(rd_n)) || stall();

         // ================================================================
         // Write channel
         // ================================================================
         if (dma_req.wr_go) begin
            wr_b            = dma_req.wr_addr;
            wr_n            = dma_req.wr_size;
            wr_next         = 0;
            seen_wr_addr    <= dma_req.wr_addr;
            seen_wr_size    <= dma_req.wr_size;
            dma_rsp.wr_done <= (dma_req.wr_size == '0);
         end else if (dma_req.wr_en && !dma_rsp.full) begin
            mem[wr_base + (byte_addr_t'(wr_cnt) << 6)] = dma_req.wr_data;
            wr_next = wr_cnt + 1;
            if (wr_next == 32'(wr_n)) begin
               dma_rsp.wr_done <= 1'b1;
            end
         end
         wr_base      <= wr_b;
         wr_lines     <= wr_n;
         wr_cnt       <= wr_next;
         dma_rsp.full <= !(wr_next < 32'(wr_n)) || stall();
      end
   end

endmodule

/* tests/afu_tb.sv */
`timescale 1ns/1ps
//==========================================================================
// Accelerator shell testbench
// Runs the copy transfers from the vector file over APB and checks the
// DMA setup, the copied lines, the checksum and the flow control
//==========================================================================

module afu_tb
   import afu_pkg::*;
();

   localparam int MAX_VEC = 32;
   localparam int FIELDS  = 5;

   logic        clk;
   logic        rst_n;
   apb_addr_t   paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   word_t       pwdata;
   word_t       prdata;
   logic        pready;
   logic        pslverr;
   dma_req_t    dma_req;
   dma_rsp_t    dma_rsp;
   int          stall_pct;
   logic        flow_err;
   byte_addr_t  seen_rd_addr;
   byte_addr_t  seen_wr_addr;
   line_count_t seen_rd_size;
   line_count_t seen_wr_size;

   // Five fields per vector, in file order
   logic [63:0] vec_mem [0:MAX_VEC*FIELDS-1];

   int unsigned cycles;
   int unsigned limit;

   afu_top dut_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .dma_req (dma_req),
      .dma_rsp (dma_rsp)
   );

   host_mem_model host_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .dma_req      (dma_req),
      .dma_rsp      (dma_rsp),
      .stall_pct    (stall_pct),
      .flow_err     (flow_err),
      .seen_rd_addr (seen_rd_addr),
      .seen_wr_addr (seen_wr_addr),
      .seen_rd_size (seen_rd_size),
      .seen_wr_size (seen_wr_size)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Global watchdog over the whole run
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout waiting for done");
         $display("** FAIL **");
         $fatal(1);
      end
   end

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   // Setup on one falling edge, access on the next, idle on the third
   task automatic apb_write(input apb_addr_t a, input word_t d);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = d;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      check_eq("apb write pready", 64'(1), 64'(pready));
      check_eq("apb write pslverr", 64'(0), 64'(pslverr));
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t a, output word_t d);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = a;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      d       = prdata;
      check_eq("apb read pready", 64'(1), 64'(pready));
      check_eq("apb read pslverr", 64'(0), 64'(pslverr));
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Source data is a hash of the seed and the word number in the transfer
   function automatic word_t gen_word(word_t seed, int idx);
      word_t x;
      x = seed ^ (word_t'(idx) * 32'h9E37_79B9);
      x = x ^ (x >> 15);
      x = x * 32'h85EB_CA6B;
      x = x ^ (x >> 13);
      return x;
   endfunction

   // Destination lines start out as a marker built from their address
   function automatic line_t marker_line(byte_addr_t a);
      return {8{a ^ 64'hA5A5_0000_5A5A_FFFF}};
   endfunction

   initial begin : main
      int          n_vec;
      int          total_words;
      byte_addr_t  ra;
      byte_addr_t  wa;
      line_count_t sz;
      word_t       seed;
      word_t       sum;
      word_t       st;
      word_t       rb;
      line_t       ln;
      line_t       got;
      byte_addr_t  la;
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      stall_pct = 0;
      cycles    = 0;
      limit     = 32'hFFFF_FFFF;
      void'($urandom(81));

      for (int k = 0; k < MAX_VEC * FIELDS; k++) begin
         vec_mem[k] = '1;
      end
      $readmemh("tests/afu_vectors.txt", vec_mem);

      // An all ones read address marks the end of the list
      n_vec       = 0;
      total_words = 0;
      while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS] !== '1) begin
         total_words += int'(vec_mem[n_vec*FIELDS+2][15:0]) * WORDS_PER_LINE;
         n_vec++;
      end
      if (n_vec == 0) begin
         $display("no vectors were read from the vector file");
         $display("** FAIL **");
         $fatal(1);
      end
      limit = 200 + 40 * total_words;

      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      apb_read(REG_STATUS, st);
      check_eq("status after reset", 64'(0), 64'(st));

      for (int v = 0; v < n_vec; v++) begin
         ra        = vec_mem[v*FIELDS];
         wa        = vec_mem[v*FIELDS+1];
         sz        = vec_mem[v*FIELDS+2][15:0];
         stall_pct = int'(vec_mem[v*FIELDS+3][7:0]);
         seed      = vec_mem[v*FIELDS+4][31:0];

         // Fill the source and mark the destination one line past the end
         sum = '0;
         for (int l = 0; l < int'(sz); l++) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
               ln[i*WORD_W +: WORD_W] = gen_word(seed, l * WORDS_PER_LINE + i);
               sum = sum + ln[i*WORD_W +: WORD_W];
            end
            host_i.mem[ra + (byte_addr_t'(l) << 6)] = ln;
         end
         for (int l = 0; l <= int'(sz); l++) begin
            la = wa + (byte_addr_t'(l) << 6);
            host_i.mem[la] = marker_line(la);
         end

         apb_write(REG_RD_ADDR_LO, ra[31:0]);
         apb_write(REG_RD_ADDR_HI, ra[63:32]);
         apb_write(REG_WR_ADDR_LO, wa[31:0]);
         apb_write(REG_WR_ADDR_HI, wa[63:32]);
         apb_write(REG_SIZE, word_t'(sz));

         apb_read(REG_RD_ADDR_LO, rb);
         check_eq($sformatf("vec%0d rd_addr_lo", v), 64'(ra[31:0]), 64'(rb));
         apb_read(REG_RD_ADDR_HI, rb);
         check_eq($sformatf("vec%0d rd_addr_hi", v), 64'(ra[63:32]), 64'(rb));
         apb_read(REG_WR_ADDR_LO, rb);
         check_eq($sformatf("vec%0d wr_addr_lo", v), 64'(wa[31:0]), 64'(rb));
         apb_read(REG_WR_ADDR_HI, rb);
         check_eq($sformatf("vec%0d wr_addr_hi", v), 64'(wa[63:32]), 64'(rb));
         apb_read(REG_SIZE, rb);
         check_eq($sformatf("vec%0d size", v), 64'(sz), 64'(rb));

         apb_write(REG_CTRL, 32'h1);
         // A new go drops the done flag of the previous transfer
         apb_read(REG_STATUS, st);
         check_eq($sformatf("vec%0d done cleared", v), 64'(0), 64'(st[0]));

         do begin
            apb_read(REG_STATUS, st);
         end while (!st[0]);

         check_eq($sformatf("vec%0d dma rd_addr", v), ra, seen_rd_addr);
         check_eq($sformatf("vec%0d dma wr_addr", v), wa, seen_wr_addr);
         check_eq($sformatf("vec%0d dma rd_size", v), 64'(sz), 64'(seen_rd_size));
         check_eq($sformatf("vec%0d dma wr_size", v), 64'(sz), 64'(seen_wr_size));

         // Every copied word must match the generated source word
         for (int l = 0; l < int'(sz); l++) begin
            got = host_i.mem[wa + (byte_addr_t'(l) << 6)];
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
               check_eq($sformatf("vec%0d line %0d word %0d", v, l, i),
                        64'(gen_word(seed, l * WORDS_PER_LINE + i)),
                        64'(got[i*WORD_W +: WORD_W]));
            end
         end
         la  = wa + (byte_addr_t'(sz) << 6);
         got = host_i.mem[la];
         ln  = marker_line(la);
         for (int i = 0; i < WORDS_PER_LINE; i++) begin
            check_eq($sformatf("vec%0d line past end word %0d", v, i),
                     64'(ln[i*WORD_W +: WORD_W]), 64'(got[i*WORD_W +: WORD_W]));
         end

         apb_read(REG_CHECKSUM, rb);
         check_eq($sformatf("vec%0d checksum", v), 64'(sum), 64'(rb));
         check_eq($sformatf("vec%0d flow control", v), 64'(0), 64'(flow_err));
      end

      $display("** PASS **");
      $finish;
   end

endmodule

/* tests/afu_vectors.txt */
// rd_addr wr_addr size stall_pct data_seed, all hex
// stall_pct is a percentage, 0x00 to 0x63
0000000000001000 0000000000100000 0001 00 00000011
0000000100002000 0000000200200000 0004 14 0000005a
0000000000004000 0000000000008000 0003 32 00c0ffee
00000000ffff0000 0000000100000000 0008 00 12345678
0000000000010000 0000000000020000 0002 50 00000bad
0000000000001000 0000000000100000 0001 00 00000077
0000000300000040 0000000400000fc0 0005 3c 0000abcd
0000000000004000 0000000000008000 0006 5a 00000001

/* list.f */
logic/afu_pkg.sv
logic/mmio_regs.sv
logic/mem_ctrl.sv
logic/word_engine.sv
logic/afu_top.sv
tests/host_mem_model.sv
tests/afu_tb.sv

/* Makefile */
# Verilator build and run for the accelerator shell testbench

TOP     ?= afu_tb
LOG     ?= sim.log
SEED    ?= 81
BUILD   ?= obj_dir
FLIST   ?= list.f
VFLAGS  ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
